//--- compile.f
hdl/core_config_pkg.sv
hdl/retire_types_pkg.sv
hdl/rename_map.sv
hdl/phys_reg_tracker.sv
hdl/phys_regfile.sv
hdl/reorder_buffer.sv
hdl/retire.sv
hdl/retire_subsystem.sv
verif/tb_clock_gen.sv
verif/retire_tb.sv

//--- Bender.yml
package:
  name: retire_subsystem

sources:
  # Packages first, then leaf modules, then the top level
  - hdl/core_config_pkg.sv
  - hdl/retire_types_pkg.sv
  - hdl/rename_map.sv
  - hdl/phys_reg_tracker.sv
  - hdl/phys_regfile.sv
  - hdl/reorder_buffer.sv
  - hdl/retire.sv
  - hdl/retire_subsystem.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/retire_tb.sv

//--- verif/retire_tb.sv
`default_nettype none

module retire_tb;
    import core_config_pkg::*;
    import retire_types_pkg::*;

    localparam int max_cycles = 2000;  // All tests together with margin

    // One dispatched instruction as the testbench remembers it
    typedef struct packed {
        inst_kind_e                kind;
        logic [arch_idx_width-1:0] arch_reg;
        logic [addr_width-1:0]     npc;
        logic [phys_idx_width-1:0] tag;       // Tag handed out at dispatch
        logic [phys_idx_width-1:0] tag_free;  // Tag returned at commit
    } dispatch_rec_t;

    // Fields expected on a commit slot
    typedef struct packed {
        logic [addr_width-1:0]     npc;
        logic [arch_idx_width-1:0] arch_reg;
        logic [data_width-1:0]     data;
        logic                      halt;
    } commit_exp_t;

    logic                      clock;
    logic                      reset;
    logic                      dispatch_valid;
    inst_kind_e                dispatch_kind;
    logic [arch_idx_width-1:0] dispatch_arch_reg;
    logic [addr_width-1:0]     dispatch_npc;
    logic [phys_idx_width-1:0] dispatch_tag;
    logic                      complete_valid;
    logic [phys_idx_width-1:0] complete_tag;
    logic [data_width-1:0]     complete_data;
    logic                      commit_valid [retire_width];
    logic [addr_width-1:0]     commit_npc [retire_width];
    logic [arch_idx_width-1:0] commit_arch_reg [retire_width];
    logic [data_width-1:0]     commit_data [retire_width];
    logic                      commit_halt [retire_width];
    logic                      halted;

    dispatch_rec_t             exp_q [$];             // In flight, oldest first
    logic [phys_idx_width-1:0] pending_q [$];         // Dispatched, not yet completed
    logic [phys_idx_width-1:0] free_model_q [$];      // Expected free list, head first
    logic [phys_idx_width-1:0] map_model [arch_regs]; // Expected rename map
    logic [data_width-1:0]     tag_data [phys_regs];  // Last data completed per tag
    logic [addr_width-1:0]     next_npc;
    integer                    seed = 18;
    int                        errors = 0;
    int                        checks = 0;
    int                        commits = 0;
    int                        dual_cycles = 0;       // Both slots committed
    int                        single_cycles = 0;
    int                        cycle_count = 0;
    logic                      halt_seen = 1'b0;      // A halt has committed
    logic                      block_watch = 1'b0;    // No commit may appear

    tb_clock_gen u_clock_gen (.clock(clock));

    retire_subsystem dut (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_kind     (dispatch_kind),
        .dispatch_arch_reg (dispatch_arch_reg),
        .dispatch_npc      (dispatch_npc),
        .dispatch_tag      (dispatch_tag),
        .complete_valid    (complete_valid),
        .complete_tag      (complete_tag),
        .complete_data     (complete_data),
        .commit_valid      (commit_valid),
        .commit_npc        (commit_npc),
        .commit_arch_reg   (commit_arch_reg),
        .commit_data       (commit_data),
        .commit_halt       (commit_halt),
        .halted            (halted)
    );

    // Expected commit of the oldest in-flight instruction
    function automatic commit_exp_t expect_commit(input dispatch_rec_t rec,
                                                  input logic [data_width-1:0] data);
        commit_exp_t exp;
        exp.npc      = rec.npc;
        exp.arch_reg = rec.arch_reg;
        exp.data     = data;                     // Value completed on its own new tag
        exp.halt     = (rec.kind == kind_halt);
        return exp;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
        end
    endtask

    // One cycle of stimulus, applied on the falling edge
    task automatic drive_cycle(input logic disp, input inst_kind_e kind, input logic comp,
                               input logic [phys_idx_width-1:0] ctag);
        dispatch_rec_t rec;
        @(negedge clock);
        dispatch_valid    = disp;
        dispatch_kind     = kind;
        dispatch_arch_reg = arch_idx_width'($unsigned($random(seed)));
        dispatch_npc      = next_npc;
        if (disp) begin
            // Free list head, stable here
            check_value(dispatch_tag, free_model_q.pop_front(), "dispatch tag");
            rec.kind     = kind;
            rec.arch_reg = dispatch_arch_reg;
            rec.npc      = next_npc;
            rec.tag      = dispatch_tag;
            if (kind == kind_alu) begin
                rec.tag_free                 = map_model[dispatch_arch_reg];  // Old mapping
                map_model[dispatch_arch_reg] = dispatch_tag;
            end else begin
                rec.tag_free = dispatch_tag;   // No destination, own tag comes back
            end
            exp_q.push_back(rec);
            pending_q.push_back(dispatch_tag);
            next_npc = next_npc + 4;
        end
        complete_valid = comp;
        complete_tag   = ctag;
        complete_data  = $random(seed);
        if (comp) begin
            tag_data[ctag] = complete_data;
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, kind_alu, 1'b0, '0);
    endtask

    // Pulls a random tag out of the pending set
    task automatic take_random_pending(output logic [phys_idx_width-1:0] tag);
        int idx;
        idx = $unsigned($random(seed)) % pending_q.size();
        tag = pending_q[idx];
        pending_q.delete(idx);
    endtask

    task automatic complete_all_random();
        logic [phys_idx_width-1:0] tag;
        while (pending_q.size() != 0) begin
            take_random_pending(tag);
            drive_cycle(1'b0, kind_alu, 1'b1, tag);
        end
    endtask

    // Idles until every in-flight instruction has committed
    task automatic drain();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
    endtask

    task automatic report_test(input string name, input int err_start, input int commit_start);
        $display("Test %s: %0d commits, %0d errors", name, commits - commit_start,
                 errors - err_start);
    endtask

    // Commit monitor, sampled on the rising edge
    always @(posedge clock) begin : compare
        dispatch_rec_t rec;
        commit_exp_t   exp;
        if (!reset) begin
            check_value(halted, halt_seen, "halted");  // Set from the cycle after the halt
            if (commit_valid[1]) begin
                check_value(commit_valid[0], 1'b1, "slot 0 valid with slot 1");
            end
            if (commit_valid[0] && commit_valid[1]) begin
                dual_cycles++;
            end else if (commit_valid[0]) begin
                single_cycles++;
            end
            for (int i = 0; i < retire_width; i++) begin
                if (commit_valid[i]) begin
                    if (block_watch) begin
                        errors++;
                        $display("Slot %0d committed at %0t while the oldest was incomplete",
                                 i, $time);
                    end
                    if (halt_seen) begin
                        errors++;
                        $display("Slot %0d committed at %0t after a halt", i, $time);
                    end
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Slot %0d committed at %0t with nothing in flight", i, $time);
                    end else begin
                        rec = exp_q.pop_front();
                        free_model_q.push_back(rec.tag_free);  // Freed at this edge, slot order
                        exp = expect_commit(rec, tag_data[rec.tag]);
                        check_value(commit_npc[i], exp.npc, $sformatf("slot %0d npc", i));
                        check_value(commit_arch_reg[i], exp.arch_reg,
                                    $sformatf("slot %0d arch reg", i));
                        check_value(commit_data[i], exp.data, $sformatf("slot %0d data", i));
                        check_value(commit_halt[i], exp.halt, $sformatf("slot %0d halt", i));
                        commits++;
                        if (exp.halt) begin
                            halt_seen = 1'b1;  // Later slots must stay quiet
                        end
                    end
                end
            end
        end
    end

    // Run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        logic [phys_idx_width-1:0] tag;
        logic [phys_idx_width-1:0] oldest;
        logic                      do_disp;
        logic                      do_comp;
        inst_kind_e                kind;
        int                        err_start;
        int                        commit_start;
        int                        dual_start;
        int                        single_start;
        int                        issued;
        reset             = 1'b1;
        dispatch_valid    = 1'b0;
        dispatch_kind     = kind_alu;
        dispatch_arch_reg = '0;
        dispatch_npc      = '0;
        complete_valid    = 1'b0;
        complete_tag      = '0;
        complete_data     = '0;
        next_npc          = 32'h0000_1000;
        for (int i = 0; i < phys_regs; i++) begin
            tag_data[i] = '0;  // Arch tags start complete with zero
        end
        for (int i = 0; i < arch_regs; i++) begin
            map_model[i] = phys_idx_width'(i);                      // Identity map
            free_model_q.push_back(phys_idx_width'(arch_regs + i));  // Tags 8 to 15
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // 1: eight writers, completed in random order
        err_start    = errors;
        commit_start = commits;
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b1, kind_alu, 1'b0, '0);
            check_value(exp_q[exp_q.size()-1].tag, arch_regs + i, "initial free list tag");
        end
        complete_all_random();
        drain();
        check_value(commits - commit_start, 8, "test 1 commits");
        report_test("1 order and data", err_start, commit_start);

        // 2: oldest left incomplete blocks the whole ROB
        err_start    = errors;
        commit_start = commits;
        block_watch  = 1'b1;
        for (int i = 0; i < 6; i++) begin
            drive_cycle(1'b1, kind_alu, 1'b0, '0);
        end
        oldest = pending_q.pop_front();
        complete_all_random();
        repeat (4) idle_cycle();
        block_watch = 1'b0;
        drive_cycle(1'b0, kind_alu, 1'b1, oldest);
        drain();
        check_value(commits - commit_start, 6, "test 2 commits");
        report_test("2 head blocking", err_start, commit_start);

        // 3: youngest first, so all six become ready together
        err_start    = errors;
        commit_start = commits;
        dual_start   = dual_cycles;
        single_start = single_cycles;
        for (int i = 0; i < 6; i++) begin
            drive_cycle(1'b1, (i % 2 != 0) ? kind_nodest : kind_alu, 1'b0, '0);
        end
        while (pending_q.size() != 0) begin
            drive_cycle(1'b0, kind_alu, 1'b1, pending_q.pop_back());
        end
        drain();
        check_value(dual_cycles - dual_start, 3, "dual commit cycles");
        check_value(single_cycles - single_start, 0, "single commit cycles");
        report_test("3 dual retirement", err_start, commit_start);

        // 4: 40 mixed instructions, never more than a full ROB in flight
        // Reused tags come back in the order the free list model predicts
        err_start    = errors;
        commit_start = commits;
        issued       = 0;
        while ((issued < 40) || (pending_q.size() != 0)) begin
            do_disp = (issued < 40) && (exp_q.size() < rob_depth)
                      && (($random(seed) & 3) != 0);
            do_comp = (pending_q.size() != 0) && (($random(seed) & 1) != 0);
            kind    = (($random(seed) & 1) != 0) ? kind_nodest : kind_alu;
            tag     = '0;
            if (do_comp) begin
                take_random_pending(tag);
            end
            drive_cycle(do_disp, kind, do_comp, tag);
            if (do_disp) begin
                issued++;
            end
        end
        drain();
        check_value(commits - commit_start, 40, "test 4 commits");
        report_test("4 tag recycling", err_start, commit_start);

        // 5: halt, then two more that must never commit
        err_start    = errors;
        commit_start = commits;
        drive_cycle(1'b1, kind_halt, 1'b0, '0);
        drive_cycle(1'b1, kind_alu, 1'b0, '0);
        drive_cycle(1'b1, kind_alu, 1'b0, '0);
        complete_all_random();
        while (!halt_seen) begin
            idle_cycle();
        end
        repeat (10) idle_cycle();
        check_value(exp_q.size(), 2, "instructions left after halt");
        check_value(halted, 1'b1, "halted after halt");
        check_value(commits - commit_start, 1, "test 5 commits");
        report_test("5 halt", err_start, commit_start);

        $display("Tests: 5, checks: %0d, errors: %0d, commits: %0d", checks, errors, commits);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock
);
    localparam int half_period = 4;  // Period of 8 time units

    // Free-running, starts low
    initial begin
        clock = 1'b0;
        forever begin
            #half_period clock = ~clock;
        end
    end

endmodule

`default_nettype wire

//--- hdl/retire_subsystem.sv
`default_nettype none

module retire_subsystem (
    input  logic                                       clock,
    input  logic                                       reset,
    // Dispatch
    input  logic                                       dispatch_valid,
    input  retire_types_pkg::inst_kind_e               dispatch_kind,
    input  logic [core_config_pkg::arch_idx_width-1:0] dispatch_arch_reg,
    input  logic [core_config_pkg::addr_width-1:0]     dispatch_npc,
    output logic [core_config_pkg::phys_idx_width-1:0] dispatch_tag,
    // Completion
    input  logic                                       complete_valid,
    input  logic [core_config_pkg::phys_idx_width-1:0] complete_tag,
    input  logic [core_config_pkg::data_width-1:0]     complete_data,
    // Commit
    output logic                                       commit_valid [core_config_pkg::retire_width],
    output logic [core_config_pkg::addr_width-1:0]     commit_npc [core_config_pkg::retire_width],
    output logic [core_config_pkg::arch_idx_width-1:0] commit_arch_reg [core_config_pkg::retire_width],
    output logic [core_config_pkg::data_width-1:0]     commit_data [core_config_pkg::retire_width],
    output logic                                       commit_halt [core_config_pkg::retire_width],
    output logic                                       halted
);
    import core_config_pkg::*;
    import retire_types_pkg::*;

    logic [phys_idx_width-1:0]     old_tag;
    logic [rob_count_width-1:0]    rob_count;
    logic [retire_count_width-1:0] retire_count;
    logic [phys_idx_width-1:0]     head_tag_new [retire_width];
    logic [phys_idx_width-1:0]     head_tag_old [retire_width];
    inst_kind_e                    head_kind [retire_width];
    logic [arch_idx_width-1:0]     head_arch_reg [retire_width];
    logic [addr_width-1:0]         head_npc [retire_width];
    logic [phys_regs-1:0]          complete_bits;
    logic                          free_valid [retire_width];
    logic [phys_idx_width-1:0]     free_tag [retire_width];
    logic [phys_idx_width-1:0]     read_tag [retire_width];
    logic [data_width-1:0]         read_data [retire_width];

    rename_map u_rename_map (.clock, .reset, .dispatch_valid, .dispatch_kind, .dispatch_arch_reg,
        .new_tag(dispatch_tag), .old_tag);

    // Free list head doubles as the dispatch tag
    phys_reg_tracker u_tracker (.clock, .reset, .alloc_valid(dispatch_valid),
        .alloc_tag(dispatch_tag), .free_valid, .free_tag, .complete_valid, .complete_tag,
        .complete_bits);

    phys_regfile u_regfile (.clock, .reset, .write_valid(complete_valid),
        .write_tag(complete_tag), .write_data(complete_data), .read_tag, .read_data);

    reorder_buffer u_rob (.clock, .reset, .dispatch_valid, .dispatch_kind, .dispatch_arch_reg,
        .dispatch_npc, .dispatch_tag_new(dispatch_tag), .dispatch_tag_old(old_tag),
        .retire_count, .rob_count, .head_tag_new, .head_tag_old, .head_kind, .head_arch_reg,
        .head_npc);

    retire u_retire (.clock, .reset, .rob_count, .head_tag_new, .head_tag_old, .head_kind,
        .head_arch_reg, .head_npc, .complete_bits, .read_data, .retire_count, .free_valid,
        .free_tag, .read_tag, .commit_valid, .commit_npc, .commit_arch_reg, .commit_data,
        .commit_halt, .halted);

endmodule

`default_nettype wire

//--- hdl/retire.sv
`default_nettype none

module retire (
    input  logic                                           clock,
    input  logic                                           reset,
    // From the ROB
    input  logic [core_config_pkg::rob_count_width-1:0]    rob_count,
    input  logic [core_config_pkg::phys_idx_width-1:0]     head_tag_new [core_config_pkg::retire_width],
    input  logic [core_config_pkg::phys_idx_width-1:0]     head_tag_old [core_config_pkg::retire_width],
    input  retire_types_pkg::inst_kind_e                   head_kind [core_config_pkg::retire_width],
    input  logic [core_config_pkg::arch_idx_width-1:0]     head_arch_reg [core_config_pkg::retire_width],
    input  logic [core_config_pkg::addr_width-1:0]         head_npc [core_config_pkg::retire_width],
    // From the tracker and register file
    input  logic [core_config_pkg::phys_regs-1:0]          complete_bits,
    input  logic [core_config_pkg::data_width-1:0]         read_data [core_config_pkg::retire_width],
    output logic [core_config_pkg::retire_count_width-1:0] retire_count,
    output logic                                           free_valid [core_config_pkg::retire_width],
    output logic [core_config_pkg::phys_idx_width-1:0]     free_tag [core_config_pkg::retire_width],
    output logic [core_config_pkg::phys_idx_width-1:0]     read_tag [core_config_pkg::retire_width],
    // Commit record
    output logic                                           commit_valid [core_config_pkg::retire_width],
    output logic [core_config_pkg::addr_width-1:0]         commit_npc [core_config_pkg::retire_width],
    output logic [core_config_pkg::arch_idx_width-1:0]     commit_arch_reg [core_config_pkg::retire_width],
    output logic [core_config_pkg::data_width-1:0]         commit_data [core_config_pkg::retire_width],
    output logic                                           commit_halt [core_config_pkg::retire_width],
    output logic                                           halted
);
    import core_config_pkg::*;
    import retire_types_pkg::*;

    retire_state_e state;
    retire_state_e state_next;
    logic          blocked;     // An older slot stopped the walk

    // In-order walk from the head
    always_comb begin
        blocked      = (state == retire_halted);
        state_next   = state;
        retire_count = '0;
        for (int i = 0; i < retire_width; i++) begin
            read_tag[i]        = head_tag_new[i];  // Result of this slot's producer
            commit_npc[i]      = head_npc[i];
            commit_arch_reg[i] = head_arch_reg[i];
            commit_data[i]     = read_data[i];
            // Occupied, complete, and nothing older in the way
            commit_valid[i] = !blocked && (i < rob_count) && complete_bits[head_tag_new[i]];
            commit_halt[i]  = commit_valid[i] && (head_kind[i] == kind_halt);
            // Commit is a prefix, so lanes stay compacted
            free_valid[i] = commit_valid[i];
            free_tag[i]   = (head_kind[i] == kind_alu) ? head_tag_old[i] : head_tag_new[i];
            if (commit_valid[i]) begin
                retire_count = retire_count + 1'b1;
            end
            if (commit_halt[i]) begin
                state_next = retire_halted;
            end
            blocked = blocked || !commit_valid[i] || commit_halt[i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= retire_running;
        end else begin
            state <= state_next;
        end
    end

    assign halted = (state == retire_halted);

    assert property (@(posedge clock) disable iff (reset)
        commit_valid[1] |-> commit_valid[0]);

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`default_nettype none

module reorder_buffer (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           dispatch_valid,
    input  retire_types_pkg::inst_kind_e                   dispatch_kind,
    input  logic [core_config_pkg::arch_idx_width-1:0]     dispatch_arch_reg,
    input  logic [core_config_pkg::addr_width-1:0]         dispatch_npc,
    input  logic [core_config_pkg::phys_idx_width-1:0]     dispatch_tag_new,
    input  logic [core_config_pkg::phys_idx_width-1:0]     dispatch_tag_old,
    input  logic [core_config_pkg::retire_count_width-1:0] retire_count,
    output logic [core_config_pkg::rob_count_width-1:0]    rob_count,
    output logic [core_config_pkg::phys_idx_width-1:0]     head_tag_new [core_config_pkg::retire_width],
    output logic [core_config_pkg::phys_idx_width-1:0]     head_tag_old [core_config_pkg::retire_width],
    output retire_types_pkg::inst_kind_e                   head_kind [core_config_pkg::retire_width],
    output logic [core_config_pkg::arch_idx_width-1:0]     head_arch_reg [core_config_pkg::retire_width],
    output logic [core_config_pkg::addr_width-1:0]         head_npc [core_config_pkg::retire_width]
);
    import core_config_pkg::*;
    import retire_types_pkg::*;

    // Entry payload, no reset
    logic [phys_idx_width-1:0] tag_new_mem [rob_depth];
    logic [phys_idx_width-1:0] tag_old_mem [rob_depth];
    inst_kind_e                kind_mem [rob_depth];
    logic [arch_idx_width-1:0] arch_reg_mem [rob_depth];
    logic [addr_width-1:0]     npc_mem [rob_depth];

    logic [rob_idx_width-1:0]  head;  // Oldest entry
    logic [rob_idx_width-1:0]  tail;  // Next write slot
    logic [rob_idx_width-1:0]  slot;

    // Two oldest entries, slot 1 may be stale when count < 2
    always_comb begin
        slot = head;
        for (int i = 0; i < retire_width; i++) begin
            slot             = head + rob_idx_width'(i);
            head_tag_new[i]  = tag_new_mem[slot];
            head_tag_old[i]  = tag_old_mem[slot];
            head_kind[i]     = kind_mem[slot];
            head_arch_reg[i] = arch_reg_mem[slot];
            head_npc[i]      = npc_mem[slot];
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            tag_new_mem[tail]  <= dispatch_tag_new;
            tag_old_mem[tail]  <= dispatch_tag_old;
            kind_mem[tail]     <= dispatch_kind;
            arch_reg_mem[tail] <= dispatch_arch_reg;
            npc_mem[tail]      <= dispatch_npc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            rob_count <= '0;
        end else begin
            head      <= head + rob_idx_width'(retire_count);  // Wraps at 8
            tail      <= tail + rob_idx_width'(dispatch_valid);
            rob_count <= rob_count + rob_count_width'(dispatch_valid)
                         - rob_count_width'(retire_count);
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> (rob_count != rob_count_width'(rob_depth)));

    // Retire never drains past the entries it was shown
    assert property (@(posedge clock) disable iff (reset)
        rob_count_width'(retire_count) <= rob_count);

endmodule

`default_nettype wire

//--- hdl/phys_regfile.sv
`default_nettype none

module phys_regfile (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       write_valid,  // Completion strobe
    input  logic [core_config_pkg::phys_idx_width-1:0] write_tag,
    input  logic [core_config_pkg::data_width-1:0]     write_data,
    input  logic [core_config_pkg::phys_idx_width-1:0] read_tag [core_config_pkg::retire_width],
    output logic [core_config_pkg::data_width-1:0]     read_data [core_config_pkg::retire_width]
);
    import core_config_pkg::*;

    logic [data_width-1:0] regs [phys_regs];

    always_ff @(posedge clock) begin
        if (reset) begin
            // Initial arch values are zero
            for (int i = 0; i < phys_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_valid) begin
            regs[write_tag] <= write_data;
        end
    end

    // Asynchronous read, no bypass
    // A same-cycle write is not yet complete to the retire stage
    always_comb begin
        for (int i = 0; i < retire_width; i++) begin
            read_data[i] = regs[read_tag[i]];
        end
    end

endmodule

`default_nettype wire

//--- hdl/phys_reg_tracker.sv
`default_nettype none

module phys_reg_tracker (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       alloc_valid,  // Pop at dispatch
    output logic [core_config_pkg::phys_idx_width-1:0] alloc_tag,
    input  logic                                       free_valid [core_config_pkg::retire_width],
    input  logic [core_config_pkg::phys_idx_width-1:0] free_tag [core_config_pkg::retire_width],
    input  logic                                       complete_valid,
    input  logic [core_config_pkg::phys_idx_width-1:0] complete_tag,
    output logic [core_config_pkg::phys_regs-1:0]      complete_bits
);
    import core_config_pkg::*;

    logic [phys_idx_width-1:0]   free_mem [phys_regs];  // Circular list of free tags
    logic [phys_idx_width-1:0]   head;                  // Next tag handed out
    logic [phys_idx_width-1:0]   tail;                  // Next free slot for a push
    logic [free_count_width-1:0] free_count;
    logic [free_count_width-1:0] push_count;            // Lanes pushed this cycle

    assign alloc_tag = free_mem[head];  // Visible before the pop edge

    // Lanes arrive compacted from lane 0
    always_comb begin
        push_count = '0;
        for (int i = 0; i < retire_width; i++) begin
            if (free_valid[i]) begin
                push_count = push_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Tags above the arch range start free
            for (int i = 0; i < phys_regs; i++) begin
                free_mem[i] <= phys_idx_width'(i + arch_regs);
            end
            head       <= '0;
            tail       <= phys_idx_width'(phys_regs - arch_regs);
            free_count <= free_count_width'(phys_regs - arch_regs);
        end else begin
            for (int i = 0; i < retire_width; i++) begin
                if (free_valid[i]) begin
                    free_mem[tail + phys_idx_width'(i)] <= free_tag[i];
                end
            end
            if (alloc_valid) begin
                head <= head + 1'b1;  // Wraps at 16
            end
            tail       <= tail + phys_idx_width'(push_count);
            free_count <= free_count + push_count - free_count_width'(alloc_valid);
        end
    end

    // Only in-flight tags read as incomplete
    always_ff @(posedge clock) begin
        if (reset) begin
            complete_bits <= '1;
        end else begin
            if (alloc_valid) begin
                complete_bits[alloc_tag] <= 1'b0;      // New producer pending
            end
            if (complete_valid) begin
                complete_bits[complete_tag] <= 1'b1;   // Already set means no effect
            end
        end
    end

    // Dispatch must not outrun the free list
    assert property (@(posedge clock) disable iff (reset)
        alloc_valid |-> (free_count != '0));

    // Completion only for a tag that was handed out and is still pending
    assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> !complete_bits[complete_tag]);

endmodule

`default_nettype wire

//--- hdl/rename_map.sv
`default_nettype none

module rename_map (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       dispatch_valid,
    input  retire_types_pkg::inst_kind_e               dispatch_kind,
    input  logic [core_config_pkg::arch_idx_width-1:0] dispatch_arch_reg,
    input  logic [core_config_pkg::phys_idx_width-1:0] new_tag,   // Head of the free list
    output logic [core_config_pkg::phys_idx_width-1:0] old_tag    // Mapping before this dispatch
);
    import core_config_pkg::*;
    import retire_types_pkg::*;

    logic [phys_idx_width-1:0] map_table [arch_regs];  // Arch reg to current tag
    logic                      remap;

    // Previous producer of the destination, recorded in the ROB
    assign old_tag = map_table[dispatch_arch_reg];

    // Only a real destination takes over the mapping
    assign remap = dispatch_valid && (dispatch_kind == kind_alu);

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, r lives in physical r
            for (int i = 0; i < arch_regs; i++) begin
                map_table[i] <= phys_idx_width'(i);
            end
        end else if (remap) begin
            map_table[dispatch_arch_reg] <= new_tag;
        end
    end

endmodule

`default_nettype wire

//--- hdl/retire_types_pkg.sv
`default_nettype none

package retire_types_pkg;

    // Instruction class carried through the ROB
    typedef enum logic [1:0] {
        kind_alu    = 2'd0,  // Writes a destination, frees the old tag
        kind_nodest = 2'd1,  // No destination, frees its own tag
        kind_halt   = 2'd2   // No destination, stops retirement
    } inst_kind_e;

    // Retire stage state
    typedef enum logic {
        retire_running = 1'b0,
        retire_halted  = 1'b1  // Sticky until reset
    } retire_state_e;

endpackage

`default_nettype wire

//--- hdl/core_config_pkg.sv
`default_nettype none

package core_config_pkg;

    // Core sizing
    localparam int arch_regs    = 8;   // Architectural registers
    localparam int phys_regs    = 16;  // Physical registers, the tag space
    localparam int rob_depth    = 8;   // ROB entries
    localparam int retire_width = 2;   // Max commits per cycle

    // Datapath widths
    localparam int data_width = 32;
    localparam int addr_width = 32;    // NPC width

    // Derived index widths
    localparam int arch_idx_width  = $clog2(arch_regs);      // 3 bits
    localparam int phys_idx_width  = $clog2(phys_regs);      // 4 bits, one tag
    localparam int rob_idx_width   = $clog2(rob_depth);      // 3 bits
    localparam int rob_count_width = $clog2(rob_depth + 1);  // Counts 0 to 8

    // Free list occupancy, 0 to phys_regs
    localparam int free_count_width = $clog2(phys_regs + 1);

    // Commits in one cycle, 0 to retire_width
    localparam int retire_count_width = $clog2(retire_width + 1);

endpackage

`default_nettype wire
